// File: src/cpu_pkg.sv
package cpu_pkg;

	// vector types
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [7:0]  mem_addr_t; // word index, not a byte address

	// multicycle control states, numbered like the older decoder
	typedef enum logic [3:0] {
		S_IDLE       = 4'd0,
		S_FETCH      = 4'd1,
		S_DECODE     = 4'd2,
		S_MEM_ACCESS = 4'd3,
		S_EXEC_MEM   = 4'd5, // address calc and i-type alu
		S_EXEC_R     = 4'd7,
		S_WRITEBACK  = 4'd8,
		S_EXEC_BR    = 4'd9
	} cpu_state_t;

	// opcodes
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_SYSTEM = 7'b1110011; // ebreak ends the run

	// alu operation codes
	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_SLL  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_OR   = 4'd8;
	localparam alu_op_t ALU_AND  = 4'd9;
	localparam alu_op_t ALU_BEQ  = 4'd10;
	localparam alu_op_t ALU_BNE  = 4'd11;
	localparam alu_op_t ALU_BLT  = 4'd12;
	localparam alu_op_t ALU_BGE  = 4'd13;
	localparam alu_op_t ALU_BLTU = 4'd14;
	localparam alu_op_t ALU_BGEU = 4'd15;

	// sub and sra select
	localparam funct7_t FUNCT7_ALT = 7'b0100000;

	// memory size and io window
	localparam int MEM_WORDS   = 256;
	localparam int IO_ADDR_BIT = 10; // byte address bit that selects io

endpackage

// File: src/alu_control.sv
`timescale 1ns/1ps

module alu_control (
	input  cpu_pkg::cpu_state_t cur_state,
	input  cpu_pkg::opcode_t    opcode,
	input  cpu_pkg::funct3_t    funct3,
	input  cpu_pkg::funct7_t    funct7,
	output cpu_pkg::alu_op_t    alu_op
);

	import cpu_pkg::*;

	always_comb begin
		alu_op = ALU_ADD; // fetch, decode, mem access, writeback
		case (cur_state)
			S_EXEC_MEM: begin
				// loads and stores keep the add for the address
				if (opcode == OP_IMM) begin
					case (funct3)
						3'b000: alu_op = ALU_ADD;  // addi
						3'b001: alu_op = ALU_SLL;  // slli
						3'b010: alu_op = ALU_SLT;  // slti
						3'b011: alu_op = ALU_SLTU; // sltiu
						3'b100: alu_op = ALU_XOR;  // xori
						3'b101: begin
							if (funct7 == FUNCT7_ALT)
								alu_op = ALU_SRA; // srai
							else
								alu_op = ALU_SRL; // srli
						end
						3'b110: alu_op = ALU_OR;   // ori
						3'b111: alu_op = ALU_AND;  // andi
						default: alu_op = ALU_ADD;
					endcase
				end
			end
			S_EXEC_R: begin
				if (opcode == OP_REG) begin
					case (funct3)
						3'b000: begin
							if (funct7 == FUNCT7_ALT)
								alu_op = ALU_SUB;
							else
								alu_op = ALU_ADD;
						end
						3'b001: alu_op = ALU_SLL;
						3'b010: alu_op = ALU_SLT;
						3'b011: alu_op = ALU_SLTU;
						3'b100: alu_op = ALU_XOR;
						3'b101: begin
							if (funct7 == FUNCT7_ALT)
								alu_op = ALU_SRA;
							else
								alu_op = ALU_SRL;
						end
						3'b110: alu_op = ALU_OR;
						3'b111: alu_op = ALU_AND;
						default: alu_op = ALU_ADD;
					endcase
				end
			end
			S_EXEC_BR: begin
				if (opcode == OP_BRANCH) begin
					case (funct3)
						3'b000: alu_op = ALU_BEQ;
						3'b001: alu_op = ALU_BNE;
						3'b100: alu_op = ALU_BLT;
						3'b101: alu_op = ALU_BGE;
						3'b110: alu_op = ALU_BLTU;
						3'b111: alu_op = ALU_BGEU;
						default: alu_op = ALU_ADD; // reserved funct3
					endcase
				end
			end
			default: alu_op = ALU_ADD;
		endcase
	end

	// Fires when the sequencer leaves EXEC_BR, so the sampled values are the
	// ones held through the branch cycle. A reserved funct3 lands here too.
	a_branch_op : assert property (@(cur_state)
		(cur_state == S_EXEC_BR) |-> (alu_op inside {[ALU_BEQ:ALU_BGEU]}))
		else $error("alu_control: non-branch op in exec_br");

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::alu_op_t alu_op,
	input  cpu_pkg::word_t   operand_a,
	input  cpu_pkg::word_t   operand_b,
	output cpu_pkg::word_t   alu_result,
	output logic             branch_taken
);

	import cpu_pkg::*;

	logic [4:0] shamt;
	logic       lt_s;
	logic       lt_u;
	logic       eq;

	assign shamt = operand_b[4:0]; // rv32 shifts use 5 bits
	assign lt_s  = $signed(operand_a) < $signed(operand_b);
	assign lt_u  = operand_a < operand_b;
	assign eq    = operand_a == operand_b;

	always_comb begin
		case (alu_op)
			ALU_ADD:  alu_result = operand_a + operand_b;
			ALU_SUB:  alu_result = operand_a - operand_b;
			ALU_SLL:  alu_result = operand_a << shamt;
			ALU_SLT:  alu_result = {31'd0, lt_s};
			ALU_SLTU: alu_result = {31'd0, lt_u};
			ALU_XOR:  alu_result = operand_a ^ operand_b;
			ALU_SRL:  alu_result = operand_a >> shamt;
			ALU_SRA:  alu_result = $signed(operand_a) >>> shamt;
			ALU_OR:   alu_result = operand_a | operand_b;
			ALU_AND:  alu_result = operand_a & operand_b;
			default:  alu_result = operand_a - operand_b; // branch compare
		endcase
	end

	always_comb begin
		case (alu_op)
			ALU_BEQ:  branch_taken = eq;
			ALU_BNE:  branch_taken = !eq;
			ALU_BLT:  branch_taken = lt_s;
			ALU_BGE:  branch_taken = !lt_s;
			ALU_BLTU: branch_taken = lt_u;
			ALU_BGEU: branch_taken = !lt_u;
			default:  branch_taken = 1'b0;
		endcase
	end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst_n,
	input  cpu_pkg::reg_addr_t rs1_addr,
	input  cpu_pkg::reg_addr_t rs2_addr,
	input  logic               rd_we,
	input  cpu_pkg::reg_addr_t rd_addr,
	input  cpu_pkg::word_t     rd_wdata,
	output cpu_pkg::word_t     rs1_data,
	output cpu_pkg::word_t     rs2_data
);

	import cpu_pkg::*;

	word_t regs [32]; // entry 0 is never written

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (rd_we && rd_addr != '0) begin
			regs[rd_addr] <= rd_wdata;
		end
	end

	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	// x0 stays zero through reset and the write guard
	a_x0_zero : assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
		else $error("reg_file: x0 read back nonzero");

endmodule

// File: src/control_fsm.sv
`timescale 1ns/1ps

module control_fsm (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  cpu_pkg::word_t      mem_rdata,
	input  cpu_pkg::word_t      alu_result,
	input  logic                branch_taken,
	input  cpu_pkg::word_t      rs1_data,
	input  cpu_pkg::word_t      rs2_data,
	output logic                done,
	output cpu_pkg::cpu_state_t cur_state,
	output cpu_pkg::opcode_t    opcode,
	output cpu_pkg::funct3_t    funct3,
	output cpu_pkg::funct7_t    funct7,
	output cpu_pkg::reg_addr_t  rs1_addr,
	output cpu_pkg::reg_addr_t  rs2_addr,
	output logic                rd_we,
	output cpu_pkg::reg_addr_t  rd_addr,
	output cpu_pkg::word_t      rd_wdata,
	output cpu_pkg::word_t      operand_a,
	output cpu_pkg::word_t      operand_b,
	output cpu_pkg::word_t      mem_addr,
	output logic                mem_we,
	output cpu_pkg::word_t      mem_wdata
);

	import cpu_pkg::*;

	cpu_state_t state, next_state;
	word_t      pc;
	word_t      inst_pc;  // address of the instruction in ir
	word_t      ir;
	word_t      mdr;
	word_t      alu_out;
	word_t      imm_i, imm_s, imm_b;
	logic       halt;

	// instruction fields
	assign opcode   = ir[6:0];
	assign rd_addr  = ir[11:7];
	assign funct3   = ir[14:12];
	assign rs1_addr = ir[19:15];
	assign rs2_addr = ir[24:20];
	assign funct7   = ir[31:25];

	assign imm_i = {{20{ir[31]}}, ir[31:20]};
	assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
	assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:       if (start) next_state = S_FETCH;
			S_FETCH:      next_state = S_DECODE;
			S_DECODE: begin
				case (opcode)
					OP_LOAD, OP_STORE, OP_IMM: next_state = S_EXEC_MEM;
					OP_REG:    next_state = S_EXEC_R;
					OP_BRANCH: next_state = S_EXEC_BR;
					OP_SYSTEM: next_state = S_IDLE; // ebreak
					default:   next_state = S_IDLE; // unknown opcode halts too
				endcase
			end
			S_EXEC_MEM:   next_state = (opcode == OP_IMM) ? S_WRITEBACK : S_MEM_ACCESS;
			S_EXEC_R:     next_state = S_WRITEBACK;
			S_MEM_ACCESS: next_state = (opcode == OP_LOAD) ? S_WRITEBACK : S_FETCH;
			S_WRITEBACK:  next_state = S_FETCH;
			S_EXEC_BR:    next_state = S_FETCH;
			default:      next_state = S_IDLE;
		endcase
	end

	assign halt = (state == S_DECODE) && (next_state == S_IDLE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
			pc    <= '0;
			done  <= 1'b0;
		end else begin
			state <= next_state;
			done  <= halt; // high in the first idle cycle
			case (state)
				S_IDLE:    if (start) pc <= '0;
				S_FETCH:   pc <= alu_result; // pc + 4
				S_EXEC_BR: if (branch_taken) pc <= alu_out;
				default:   pc <= pc;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_FETCH) begin
			ir      <= mem_rdata;
			inst_pc <= pc;
		end
		if (state == S_MEM_ACCESS)
			mdr <= mem_rdata;
		if (state == S_DECODE || state == S_EXEC_MEM || state == S_EXEC_R)
			alu_out <= alu_result; // branch target, address or result
	end

	// operand steering
	always_comb begin
		operand_a = pc;
		operand_b = 32'd4;
		case (state)
			S_DECODE: begin
				operand_a = inst_pc;
				operand_b = imm_b;
			end
			S_EXEC_MEM: begin
				operand_a = rs1_data;
				operand_b = (opcode == OP_STORE) ? imm_s : imm_i;
			end
			S_EXEC_R, S_EXEC_BR: begin
				operand_a = rs1_data;
				operand_b = rs2_data;
			end
			default: ;
		endcase
	end

	assign cur_state = state;
	assign mem_addr  = (state == S_MEM_ACCESS) ? alu_out : pc;
	assign mem_we    = (state == S_MEM_ACCESS) && (opcode == OP_STORE);
	assign mem_wdata = rs2_data;
	assign rd_we     = (state == S_WRITEBACK);
	assign rd_wdata  = (opcode == OP_LOAD) ? mdr : alu_out;

	// a store uses the address summed in the cycle before
	a_we_store : assert property (@(posedge clk) disable iff (!rst_n)
		mem_we |-> ($past(state) == S_EXEC_MEM && mem_addr == $past(alu_result)))
		else $error("control_fsm: store not addressed from exec_mem");

	a_state_legal : assert property (@(posedge clk) disable iff (!rst_n)
		state inside {S_IDLE, S_FETCH, S_DECODE, S_MEM_ACCESS,
			S_EXEC_MEM, S_EXEC_R, S_WRITEBACK, S_EXEC_BR})
		else $error("control_fsm: illegal state %0d", state);

endmodule

// File: src/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem (
	input  logic               clk,
	input  logic               load_we,
	input  cpu_pkg::mem_addr_t load_addr,
	input  cpu_pkg::word_t     load_wdata,
	input  cpu_pkg::word_t     mem_addr,
	input  logic               mem_we,
	input  cpu_pkg::word_t     mem_wdata,
	output cpu_pkg::word_t     mem_rdata,
	output logic               io_strobe,
	output cpu_pkg::word_t     io_addr,
	output cpu_pkg::word_t     io_wdata
);

	import cpu_pkg::*;

	word_t     mem [MEM_WORDS];
	mem_addr_t word_idx;
	logic      is_io;

	assign word_idx = mem_addr[$bits(mem_addr_t)+1:2]; // byte to word
	assign is_io    = mem_addr[IO_ADDR_BIT];

	always_ff @(posedge clk) begin
		if (load_we)
			mem[load_addr] <= load_wdata;
		else if (mem_we && !is_io)
			mem[word_idx] <= mem_wdata;
	end

	assign mem_rdata = mem[word_idx]; // async read

	// io stores bypass the array
	assign io_strobe = mem_we && is_io;
	assign io_addr   = mem_addr;
	assign io_wdata  = mem_wdata;

	a_port_excl : assert property (@(posedge clk) !(load_we && mem_we))
		else $error("mem_subsystem: loader write while cpu stores");

endmodule

// File: src/mc_cpu_top.sv
`timescale 1ns/1ps

module mc_cpu_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	output logic               done,
	input  logic               load_we,
	input  cpu_pkg::mem_addr_t load_addr,
	input  cpu_pkg::word_t     load_wdata,
	output logic               io_strobe,
	output cpu_pkg::word_t     io_addr,
	output cpu_pkg::word_t     io_wdata
);

	import cpu_pkg::*;

	cpu_state_t cur_state;
	opcode_t    opcode;
	funct3_t    funct3;
	funct7_t    funct7;
	alu_op_t    alu_op;
	reg_addr_t  rs1_addr, rs2_addr, rd_addr;
	word_t      rs1_data, rs2_data, rd_wdata;
	logic       rd_we;
	word_t      operand_a, operand_b, alu_result;
	logic       branch_taken;
	word_t      mem_addr, mem_wdata, mem_rdata;
	logic       mem_we;

	control_fsm fsm_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.mem_rdata    (mem_rdata),
		.alu_result   (alu_result),
		.branch_taken (branch_taken),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.done         (done),
		.cur_state    (cur_state),
		.opcode       (opcode),
		.funct3       (funct3),
		.funct7       (funct7),
		.rs1_addr     (rs1_addr),
		.rs2_addr     (rs2_addr),
		.rd_we        (rd_we),
		.rd_addr      (rd_addr),
		.rd_wdata     (rd_wdata),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.mem_addr     (mem_addr),
		.mem_we       (mem_we),
		.mem_wdata    (mem_wdata)
	);

	alu_control alu_ctrl_i (
		.cur_state (cur_state),
		.opcode    (opcode),
		.funct3    (funct3),
		.funct7    (funct7),
		.alu_op    (alu_op)
	);

	alu alu_i (
		.alu_op       (alu_op),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.alu_result   (alu_result),
		.branch_taken (branch_taken)
	);

	reg_file rf_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rd_we    (rd_we),
		.rd_addr  (rd_addr),
		.rd_wdata (rd_wdata),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	mem_subsystem mem_i (
		.clk        (clk),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_wdata (load_wdata),
		.mem_addr   (mem_addr),
		.mem_we     (mem_we),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.io_strobe  (io_strobe),
		.io_addr    (io_addr),
		.io_wdata   (io_wdata)
	);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1; // two edges with reset low
	end

endmodule

// File: testbench/tb_mc_cpu.sv
`timescale 1ns/1ps

module tb_mc_cpu;

	import cpu_pkg::*;

	localparam word_t EBREAK       = 32'h0010_0073;
	localparam int    DATA_IDX     = 192; // byte address 0x300
	localparam int    SETUP_CYCLES = 32;

	logic      clk;
	logic      rst_n;
	logic      start;
	logic      done;
	logic      load_we;
	mem_addr_t load_addr;
	word_t     load_wdata;
	logic      io_strobe;
	word_t     io_addr;
	word_t     io_wdata;

	word_t image [MEM_WORDS]; // next memory image for the loader
	word_t m_mem [MEM_WORDS];  // reference model state
	word_t m_regs [32];
	word_t exp_addr [$];
	word_t exp_data [$];
	word_t act_addr [$];
	word_t act_data [$];
	int    prog_len;
	int    io_slot;
	int    last_cycles;
	word_t rng_state    = 32'h1930;
	int    cycle_count  = 0;
	int    cycle_limit  = 4 * SETUP_CYCLES;
	int    checks       = 0;
	int    value_errors = 0;
	int    proto_errors = 0;

	tb_clock_gen clk_gen_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	mc_cpu_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.done       (done),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.load_wdata (load_wdata),
		.io_strobe  (io_strobe),
		.io_addr    (io_addr),
		.io_wdata   (io_wdata)
	);

	function automatic word_t rand_word();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic word_t r_inst(funct7_t f7, funct3_t f3, reg_addr_t rd,
		reg_addr_t rs1, reg_addr_t rs2);
		return {f7, rs2, rs1, f3, rd, OP_REG};
	endfunction

	function automatic word_t i_inst(opcode_t op, funct3_t f3, reg_addr_t rd,
		reg_addr_t rs1, logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic word_t s_inst(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
	endfunction

	function automatic word_t b_inst(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
		logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
	endfunction

	// rv32i arithmetic by funct3, alt picks sub and sra
	function automatic word_t alu_ref(funct3_t f3, logic alt, word_t a, word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(funct3_t f3, word_t a, word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// instruction-level model, also counts the expected cycles
	task automatic model_run(output int cycles);
		word_t   pc;
		word_t   pc_next;
		word_t   inst;
		word_t   a;
		word_t   b;
		word_t   addr;
		word_t   imm_i;
		word_t   imm_s;
		word_t   imm_b;
		funct3_t f3;
		reg_addr_t rd;
		logic    alt;
		bit      running;
		int      steps;
		pc      = '0;
		cycles  = 1;
		running = 1'b1;
		steps   = 0;
		exp_addr.delete();
		exp_data.delete();
		while (running) begin
			inst    = m_mem[pc[9:2]];
			rd      = inst[11:7];
			f3      = inst[14:12];
			a       = m_regs[inst[19:15]];
			b       = m_regs[inst[24:20]];
			imm_i   = {{20{inst[31]}}, inst[31:20]};
			imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b   = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			alt     = (inst[31:25] == FUNCT7_ALT);
			pc_next = pc + 32'd4;
			case (inst[6:0])
				OP_REG: begin
					if (rd != '0)
						m_regs[rd] = alu_ref(f3, alt, a, b);
					cycles += 4;
				end
				OP_IMM: begin
					if (rd != '0)
						m_regs[rd] = alu_ref(f3, alt && f3 == 3'd5, a, imm_i); // only srai
					cycles += 4;
				end
				OP_LOAD: begin
					addr = a + imm_i;
					if (rd != '0)
						m_regs[rd] = m_mem[addr[9:2]];
					cycles += 5;
				end
				OP_STORE: begin
					addr = a + imm_s;
					if (addr[IO_ADDR_BIT]) begin
						exp_addr.push_back(addr);
						exp_data.push_back(b);
					end else begin
						m_mem[addr[9:2]] = b;
					end
					cycles += 4;
				end
				OP_BRANCH: begin
					if (branch_ref(f3, a, b))
						pc_next = pc + imm_b;
					cycles += 3;
				end
				default: begin
					cycles += 2; // ebreak or unknown opcode
					running = 1'b0;
				end
			endcase
			pc = pc_next;
			steps++;
			if (steps > 1000) begin
				$display("reference model: program never reached ebreak");
				proto_errors++;
				running = 1'b0;
			end
		end
	endtask

	task automatic new_program();
		for (int i = 0; i < MEM_WORDS; i++)
			image[i] = {4{i[7:0]}} ^ 32'h5a3c_c3a5; // fill, never executed
		prog_len = 0;
		io_slot  = 0;
		image[0] = i_inst(OP_IMM, 3'd0, 5'd31, 5'd0, 12'h400); // x31 = io base
		prog_len = 1;
	endtask

	task automatic emit(input word_t inst);
		image[prog_len] = inst;
		prog_len++;
	endtask

	// result lands in x3 and goes to the next io slot
	task automatic emit_and_store(input word_t inst);
		emit(inst);
		emit(s_inst(5'd3, 5'd31, 12'(io_slot * 4)));
		io_slot++;
	endtask

	task automatic load_image();
		cycle_limit += 4 * (MEM_WORDS + 2);
		for (int i = 0; i < MEM_WORDS; i++) begin
			@(posedge clk);
			load_we    <= 1'b1;
			load_addr  <= mem_addr_t'(i);
			load_wdata <= image[i];
			m_mem[i] = image[i];
		end
		@(posedge clk);
		load_we <= 1'b0;
	endtask

	task automatic run_dut(output int cycles);
		bit finished;
		cycles   = 0;
		finished = 1'b0;
		act_addr.delete();
		act_data.delete();
		@(posedge clk);
		start <= 1'b1;
		while (!finished) begin
			@(posedge clk);
			start <= 1'b0;
			if (io_strobe) begin
				act_addr.push_back(io_addr);
				act_data.push_back(io_wdata);
			end
			if (done)
				finished = 1'b1;
			else
				cycles++;
		end
	endtask

	task automatic run_and_check(input string name);
		int exp_cycles;
		int act_cycles;
		int n;
		model_run(exp_cycles);
		cycle_limit += 4 * exp_cycles;
		run_dut(act_cycles);
		last_cycles = act_cycles;
		checks++;
		if (act_cycles != exp_cycles) begin
			$display("FAILED %s cycles: expected %0d, actual %0d", name, exp_cycles, act_cycles);
			value_errors++;
		end
		if (act_addr.size() != exp_addr.size()) begin
			$display("%s: the DUT made %0d io stores where %0d were expected",
				name, act_addr.size(), exp_addr.size());
			proto_errors++;
		end
		n = (act_addr.size() < exp_addr.size()) ? act_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			checks += 2;
			if (act_addr[i] !== exp_addr[i]) begin
				$display("FAILED %s io_addr[%0d]: expected %h, actual %h",
					name, i, exp_addr[i], act_addr[i]);
				value_errors++;
			end
			if (act_data[i] !== exp_data[i]) begin
				$display("FAILED %s io_wdata[%0d]: expected %h, actual %h",
					name, i, exp_data[i], act_data[i]);
				value_errors++;
			end
		end
	endtask

	task automatic load_and_run(input string name);
		load_image();
		run_and_check(name);
	endtask

	task automatic r_type_ops();
		for (int n = 0; n < 3; n++) begin
			new_program();
			image[DATA_IDX]     = rand_word();
			image[DATA_IDX + 1] = rand_word();
			emit(i_inst(OP_LOAD, 3'd2, 5'd1, 5'd0, 12'h300));
			emit(i_inst(OP_LOAD, 3'd2, 5'd2, 5'd0, 12'h304));
			for (int f = 0; f < 8; f++) begin
				emit_and_store(r_inst(7'd0, funct3_t'(f), 5'd3, 5'd1, 5'd2));
				if (f == 0 || f == 5)
					emit_and_store(r_inst(FUNCT7_ALT, funct3_t'(f), 5'd3, 5'd1, 5'd2));
			end
			emit(EBREAK);
			load_and_run("r_type");
		end
	endtask

	task automatic i_type_ops();
		for (int n = 0; n < 2; n++) begin
			new_program();
			image[DATA_IDX]     = rand_word();
			image[DATA_IDX + 1] = rand_word() | 32'h8000_0000; // negative operand
			emit(i_inst(OP_LOAD, 3'd2, 5'd1, 5'd0, 12'h300));
			emit(i_inst(OP_LOAD, 3'd2, 5'd2, 5'd0, 12'h304));
			emit_and_store(i_inst(OP_IMM, 3'd0, 5'd3, 5'd1, 12'hff9)); // addi -7
			emit_and_store(i_inst(OP_IMM, 3'd2, 5'd3, 5'd2, 12'h005)); // slti, rs1 < 0
			emit_and_store(i_inst(OP_IMM, 3'd3, 5'd3, 5'd2, 12'h005)); // sltiu sees it huge
			emit_and_store(i_inst(OP_IMM, 3'd2, 5'd3, 5'd1, 12'hfff));
			emit_and_store(i_inst(OP_IMM, 3'd3, 5'd3, 5'd1, 12'hfff));
			emit_and_store(i_inst(OP_IMM, 3'd4, 5'd3, 5'd1, 12'h8a5));
			emit_and_store(i_inst(OP_IMM, 3'd6, 5'd3, 5'd1, 12'h0f0));
			emit_and_store(i_inst(OP_IMM, 3'd7, 5'd3, 5'd2, 12'hf0f));
			emit_and_store(i_inst(OP_IMM, 3'd1, 5'd3, 5'd1, 12'h007)); // slli
			emit_and_store(i_inst(OP_IMM, 3'd5, 5'd3, 5'd2, 12'h009)); // srli
			emit_and_store(i_inst(OP_IMM, 3'd5, 5'd3, 5'd2, 12'h409)); // srai
			emit(EBREAK);
			load_and_run("i_type");
		end
	endtask

	task automatic load_store();
		new_program();
		image[DATA_IDX]     = rand_word();
		image[DATA_IDX + 1] = rand_word();
		emit(i_inst(OP_LOAD, 3'd2, 5'd1, 5'd0, 12'h300));
		emit(i_inst(OP_LOAD, 3'd2, 5'd2, 5'd0, 12'h304));
		emit(i_inst(OP_IMM, 3'd0, 5'd4, 5'd0, 12'h320));
		emit(s_inst(5'd1, 5'd4, 12'h008));
		emit(s_inst(5'd2, 5'd4, 12'hffc)); // negative offset
		emit(i_inst(OP_LOAD, 3'd2, 5'd5, 5'd4, 12'h008));
		emit(i_inst(OP_LOAD, 3'd2, 5'd6, 5'd4, 12'hffc));
		emit(s_inst(5'd5, 5'd31, 12'h000));
		emit(s_inst(5'd6, 5'd31, 12'h024));
		emit(i_inst(OP_IMM, 3'd0, 5'd7, 5'd0, 12'h7f0));
		emit(s_inst(5'd5, 5'd7, 12'hff0)); // io at 0x7e0
		emit(EBREAK);
		load_and_run("load_store");
	endtask

	// marker x3 ends at 0 when taken, 1 when not
	task automatic branch_case(input funct3_t f3, input reg_addr_t rs1, input reg_addr_t rs2);
		emit(i_inst(OP_IMM, 3'd0, 5'd3, 5'd0, 12'h000));
		emit(b_inst(f3, rs1, rs2, 13'd8));
		emit_and_store(i_inst(OP_IMM, 3'd0, 5'd3, 5'd3, 12'h001));
	endtask

	task automatic branch_paths();
		new_program();
		emit(i_inst(OP_IMM, 3'd0, 5'd1, 5'd0, 12'hffb)); // -5
		emit(i_inst(OP_IMM, 3'd0, 5'd2, 5'd0, 12'h003));
		emit(i_inst(OP_IMM, 3'd0, 5'd8, 5'd0, 12'h003));
		for (int f = 0; f < 8; f++) begin
			if (f != 2 && f != 3) begin
				branch_case(funct3_t'(f), 5'd1, 5'd2);
				branch_case(funct3_t'(f), 5'd2, 5'd1);
				branch_case(funct3_t'(f), 5'd2, 5'd8);
			end
		end
		emit(EBREAK);
		load_and_run("branch");
	endtask

	task automatic x0_and_restart();
		new_program();
		image[DATA_IDX] = rand_word() | 32'h1; // never zero
		emit(i_inst(OP_IMM, 3'd0, 5'd0, 5'd0, 12'h07b));
		emit(i_inst(OP_LOAD, 3'd2, 5'd0, 5'd0, 12'h300));
		emit(s_inst(5'd0, 5'd31, 12'h000));
		emit(i_inst(OP_IMM, 3'd0, 5'd12, 5'd12, 12'h001)); // counts the runs
		emit(s_inst(5'd12, 5'd31, 12'h004));
		emit(EBREAK);
		load_and_run("x0");
		checks++;
		if (act_data.size() > 0 && act_data[0] !== 32'd0) begin
			$display("FAILED x0 read: expected %h, actual %h", 32'd0, act_data[0]);
			value_errors++;
		end
		run_and_check("restart"); // no reload, registers carry over
	endtask

	task automatic cycle_count_mix();
		new_program();                                     // i-type 4
		emit(i_inst(OP_LOAD, 3'd2, 5'd1, 5'd0, 12'h300)); // 5
		emit(r_inst(7'd0, 3'd0, 5'd2, 5'd1, 5'd1));       // 4
		emit(s_inst(5'd2, 5'd0, 12'h308));                // 4
		emit(s_inst(5'd2, 5'd31, 12'h000));               // 4
		emit(b_inst(3'd0, 5'd1, 5'd1, 13'd8));            // 3, taken
		emit(i_inst(OP_IMM, 3'd0, 5'd2, 5'd0, 12'h001));
		emit(b_inst(3'd1, 5'd1, 5'd1, 13'd8));            // 3, not taken
		emit(32'h0000_007f);                               // unknown opcode halts, 2
		load_and_run("cycle_count");
		checks++;
		if (last_cycles != 30) begin
			$display("FAILED cycle_count total: expected %0d, actual %0d", 30, last_cycles);
			value_errors++;
		end
	endtask

	initial begin
		start      = 1'b0;
		load_we    = 1'b0;
		load_addr  = '0;
		load_wdata = '0;
		for (int i = 0; i < 32; i++)
			m_regs[i] = '0;
		wait (rst_n === 1'b1);
		@(posedge clk);
		r_type_ops();
		i_type_ops();
		load_store();
		branch_paths();
		x0_and_restart();
		cycle_count_mix();
		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, proto_errors);
		if (value_errors == 0 && proto_errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog, the budget grows as each load and run is queued
	initial begin
		while (cycle_count <= cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, the DUT never raised done", cycle_count);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: files.f
src/cpu_pkg.sv
src/alu_control.sv
src/alu.sv
src/reg_file.sv
src/control_fsm.sv
src/mem_subsystem.sv
src/mc_cpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mc_cpu.sv

// File: Bender.yml
package:
  name: mc_cpu

sources:
  - files:
      - src/cpu_pkg.sv
      - src/alu_control.sv
      - src/alu.sv
      - src/reg_file.sv
      - src/control_fsm.sv
      - src/mem_subsystem.sv
      - src/mc_cpu_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_mc_cpu.sv
